/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP   = tb_lsq_unit
FLIST = flist.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* data_mem.sv */
`timescale 1ns/1ps

module data_mem #(
    parameter int MEM_LATENCY = 3,
    parameter int MEM_WORDS   = 256
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   data_read,
    input  logic                   data_write,
    input  rv32i_types::rv32i_word data_mem_address,
    input  logic [3:0]             data_mbe,
    input  rv32i_types::rv32i_word wdata,
    output logic                   data_mem_resp,
    output rv32i_types::rv32i_word rdata
);
    import rv32i_types::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);
    localparam int CNT_W  = $clog2(MEM_LATENCY + 2);

    rv32i_word         mem [MEM_WORDS];
    logic [ADDR_W-1:0] word_idx;
    logic [CNT_W-1:0]  wait_cnt;  // cycles the current request has been held
    logic              req;
    rv32i_word         wdata_lane;

    assign req      = data_read || data_write;
    assign word_idx = data_mem_address[ADDR_W+1:2];

    // store data comes in low-justified, move it to the addressed lanes
    assign wdata_lane = wdata << {data_mem_address[1:0], 3'b000};

    assign data_mem_resp = req && (wait_cnt == CNT_W'(MEM_LATENCY));
    assign rdata         = (data_mem_resp && data_read) ? mem[word_idx] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (!req || data_mem_resp) begin
            wait_cnt <= '0;  // next request starts fresh
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (data_mem_resp && data_write) begin
            for (int b = 0; b < 4; b++) begin
                if (data_mbe[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata_lane[8*b +: 8];
                end
            end
        end
    end

endmodule

/* flist.f */
rv32i_types.sv
tomasula_types.sv
lsq.sv
data_mem.sv
load_align.sv
lsq_unit.sv
tb_lsq_unit.sv

/* load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       finished_entry,
    input  tomasula_types::alu_word    finished_entry_data,
    input  tomasula_types::op_t        load_type,
    input  logic [1:0]                 addr_offset,
    input  rv32i_types::rv32i_word     rdata,
    output logic                       result_valid,
    output tomasula_types::load_result result
);
    import rv32i_types::*;
    import tomasula_types::*;

    rv32i_word lane;      // addressed byte or half moved down to bit 0
    rv32i_word ext_data;

    assign lane = rdata >> {addr_offset, 3'b000};

    always_comb begin
        case (load_type)
            LB:      ext_data = {{24{lane[7]}}, lane[7:0]};
            LBU:     ext_data = {24'b0, lane[7:0]};
            LH:      ext_data = {{16{lane[15]}}, lane[15:0]};
            LHU:     ext_data = {16'b0, lane[15:0]};
            default: ext_data = lane;  // LW, offset is zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= finished_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (finished_entry) begin
            result.tag  <= finished_entry_data.tag;
            result.data <= ext_data;
        end
    end

endmodule

/* lsq.sv */
`timescale 1ns/1ps

module lsq #(
    parameter int LSQ_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  logic                       flush_ip,
    input  tomasula_types::res_word    res_in,
    input  tomasula_types::cdb_data    cdb [tomasula_types::ROB_ENTRIES],
    input  logic [7:0]                 rob_invalidated_n,
    input  logic [7:0]                 robs_calculated,
    input  tomasula_types::rob_tag_t   rob_head_ptr,
    input  logic                       data_mem_resp,
    output logic                       finished_entry,
    output tomasula_types::alu_word    finished_entry_data,
    output logic                       full,
    output rv32i_types::rv32i_reg      wdata_reg,
    output logic                       data_read,
    output logic                       data_write,
    output rv32i_types::rv32i_word     data_mem_address,
    output tomasula_types::op_t        load_type,
    output logic [3:0]                 data_mbe
);
    import rv32i_types::*;
    import tomasula_types::*;

    localparam int PTR_W = $clog2(LSQ_DEPTH);

    typedef enum logic [1:0] {
        RESET,
        ACTIVE,
        FLUSH
    } lsq_state_t;

    lsq_state_t state, next_state;

    logic [PTR_W-1:0]     head_ptr, tail_ptr;
    logic [LSQ_DEPTH-1:0] allocated;
    logic [LSQ_DEPTH-1:0] addr_rdy;     // base operand present
    logic [LSQ_DEPTH-1:0] invalidated;  // squashed by a flush
    logic [LSQ_DEPTH-1:0] wake;
    res_word              entries [LSQ_DEPTH];
    res_word              head;
    res_word              alloc_word;
    rv32i_word            addr;
    logic                 head_is_load;
    logic                 head_issue;
    logic                 head_squashed;
    logic                 head_retire;
    logic                 alloc_en;

    assign head          = entries[head_ptr];
    assign head_is_load  = head.op > SW;
    assign addr          = head.src1_data + head.src2_data;
    assign alloc_en      = load && !full;

    // head may go to memory only when the ROB says it is oldest
    assign head_issue = (state != RESET) && allocated[head_ptr] && addr_rdy[head_ptr]
                        && (rob_head_ptr == head.rd_tag);

    // also catch a squash that lands in the response cycle
    assign head_squashed = invalidated[head_ptr]
                           || (flush_ip && !rob_invalidated_n[head.rd_tag]);

    // squashed stores never touch memory and just drop out
    assign head_retire = allocated[head_ptr]
                         && (data_mem_resp || (!head_is_load && invalidated[head_ptr]));

    assign data_read        = head_issue && head_is_load;
    assign data_write       = head_issue && !head_is_load && !invalidated[head_ptr];
    assign data_mem_address = (data_read || data_write) ? addr : '0;
    assign wdata_reg        = data_write ? head.src2_reg : '0;
    assign load_type        = head.op;
    assign finished_entry   = data_mem_resp && head_is_load && !head_squashed;

    always_comb begin
        finished_entry_data.op        = head.op;
        finished_entry_data.funct3    = head.funct3;
        finished_entry_data.funct7    = head.funct7;
        finished_entry_data.src1_data = head.src1_data;
        finished_entry_data.src2_data = head.src2_data;
        finished_entry_data.pc        = head.pc;
        finished_entry_data.tag       = head.rd_tag;
    end

    always_comb begin
        case (head.op)
            SW:      data_mbe = 4'b1111;
            SH:      data_mbe = 4'b0011 << addr[1:0];
            SB:      data_mbe = 4'b0001 << addr[1:0];
            default: data_mbe = 4'b1111;  // loads read the whole word
        endcase
    end

    always_comb begin
        case (state)
            ACTIVE:  full = &allocated;
            default: full = 1'b1;  // no allocation outside ACTIVE
        endcase
    end

    // base operand may already sit on the cdb when the entry arrives
    always_comb begin
        alloc_word = res_in;
        if (!res_in.src1_valid && robs_calculated[res_in.src1_tag]) begin
            alloc_word.src1_data  = cdb[res_in.src1_tag].data;
            alloc_word.src1_valid = 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            wake[i] = allocated[i] && !addr_rdy[i] && robs_calculated[entries[i].src1_tag];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET:  next_state = ACTIVE;
            ACTIVE: begin
                if (flush_ip && !data_mem_resp) begin
                    next_state = FLUSH;
                end
            end
            FLUSH: begin
                // wait out the access in flight, or leave once flush ends idle
                if (data_mem_resp || (!flush_ip && !data_read && !data_write)) begin
                    next_state = ACTIVE;
                end
            end
            default: next_state = RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= RESET;
            head_ptr    <= '0;
            tail_ptr    <= '0;
            allocated   <= '0;
            addr_rdy    <= '0;
            invalidated <= '0;
        end else begin
            state <= next_state;
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                if (allocated[i] && flush_ip && !rob_invalidated_n[entries[i].rd_tag]) begin
                    invalidated[i] <= 1'b1;
                end
                if (wake[i]) begin
                    addr_rdy[i] <= 1'b1;
                end
            end
            if (alloc_en) begin
                allocated[tail_ptr]   <= 1'b1;
                addr_rdy[tail_ptr]    <= alloc_word.src1_valid;
                invalidated[tail_ptr] <= flush_ip && !rob_invalidated_n[res_in.rd_tag];
                tail_ptr              <= tail_ptr + 1'b1;
            end
            // retire last so a freed slot comes back clean
            if (head_retire) begin
                allocated[head_ptr]   <= 1'b0;
                addr_rdy[head_ptr]    <= 1'b0;
                invalidated[head_ptr] <= 1'b0;
                head_ptr              <= head_ptr + 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            if (wake[i]) begin
                entries[i].src1_data  <= cdb[entries[i].src1_tag].data;
                entries[i].src1_valid <= 1'b1;
            end
        end
        if (alloc_en) begin
            entries[tail_ptr] <= alloc_word;
        end
    end

endmodule

/* lsq_unit.sv */
`timescale 1ns/1ps

module lsq_unit #(
    parameter int LSQ_DEPTH   = 4,
    parameter int MEM_LATENCY = 3,
    parameter int MEM_WORDS   = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  tomasula_types::res_word    res_in,
    input  tomasula_types::cdb_data    cdb [tomasula_types::ROB_ENTRIES],
    input  logic [7:0]                 robs_calculated,
    input  tomasula_types::rob_tag_t   rob_head_ptr,
    input  logic                       flush_ip,
    input  logic [7:0]                 rob_invalidated_n,
    input  rv32i_types::rv32i_word     wdata,
    output logic                       full,
    output rv32i_types::rv32i_reg      wdata_reg,
    output logic                       result_valid,
    output tomasula_types::load_result result
);
    import rv32i_types::*;
    import tomasula_types::*;

    logic       data_read;
    logic       data_write;
    logic       data_mem_resp;
    logic [3:0] data_mbe;
    rv32i_word  data_mem_address;
    rv32i_word  rdata;
    logic       finished_entry;
    alu_word    finished_entry_data;
    op_t        load_type;

    lsq #(
        .LSQ_DEPTH(LSQ_DEPTH)
    ) lsq_i (
        .clk                (clk),
        .rst                (rst),
        .load               (load),
        .flush_ip           (flush_ip),
        .res_in             (res_in),
        .cdb                (cdb),
        .rob_invalidated_n  (rob_invalidated_n),
        .robs_calculated    (robs_calculated),
        .rob_head_ptr       (rob_head_ptr),
        .data_mem_resp      (data_mem_resp),
        .finished_entry     (finished_entry),
        .finished_entry_data(finished_entry_data),
        .full               (full),
        .wdata_reg          (wdata_reg),
        .data_read          (data_read),
        .data_write         (data_write),
        .data_mem_address   (data_mem_address),
        .load_type          (load_type),
        .data_mbe           (data_mbe)
    );

    // wdata is the register file answer to wdata_reg
    data_mem #(
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_WORDS  (MEM_WORDS)
    ) data_mem_i (
        .clk             (clk),
        .rst             (rst),
        .data_read       (data_read),
        .data_write      (data_write),
        .data_mem_address(data_mem_address),
        .data_mbe        (data_mbe),
        .wdata           (wdata),
        .data_mem_resp   (data_mem_resp),
        .rdata           (rdata)
    );

    load_align load_align_i (
        .clk                (clk),
        .rst                (rst),
        .finished_entry     (finished_entry),
        .finished_entry_data(finished_entry_data),
        .load_type          (load_type),
        .addr_offset        (data_mem_address[1:0]),
        .rdata              (rdata),
        .result_valid       (result_valid),
        .result             (result)
    );

endmodule

/* rv32i_types.sv */
package rv32i_types;

    // base integer ISA widths
    parameter int XLEN     = 32;
    parameter int NUM_REGS = 32;
    parameter int REG_IDX_W = $clog2(NUM_REGS);

    // one data or address word
    typedef logic [XLEN-1:0] rv32i_word;

    // architectural register index, x0..x31
    typedef logic [REG_IDX_W-1:0] rv32i_reg;

endpackage

/* tb_lsq_unit.sv */
`timescale 1ns/1ps

module tb_lsq_unit;
    import rv32i_types::*;
    import tomasula_types::*;

    localparam int LSQ_DEPTH      = 4;
    localparam int MEM_LATENCY    = 3;
    localparam int MEM_WORDS      = 256;
    localparam int NUM_TESTS      = 5;
    localparam int CLK_PERIOD     = 4;
    localparam int RESULT_TIMEOUT = 50;  // cycles
    localparam int WORD_MSB       = $clog2(MEM_WORDS) + 1;

    logic       clk;
    logic       rst;
    logic       load;
    res_word    res_in;
    cdb_data    cdb [ROB_ENTRIES];
    logic [7:0] robs_calculated;
    rob_tag_t   rob_head_ptr;
    logic       flush_ip;
    logic [7:0] rob_invalidated_n;
    rv32i_word  wdata;
    logic       full;
    rv32i_reg   wdata_reg;
    logic       result_valid;
    load_result result;

    rv32i_word  regfile [32];
    rv32i_word  ref_mem [MEM_WORDS];  // expected memory contents
    rob_tag_t   next_tag;
    int         checks;
    int         errors;

    assign wdata = regfile[wdata_reg];  // register file read port answering in the same cycle

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    lsq_unit #(
        .LSQ_DEPTH  (LSQ_DEPTH),
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_WORDS  (MEM_WORDS)
    ) lsq_unit_i (
        .clk              (clk),
        .rst              (rst),
        .load             (load),
        .res_in           (res_in),
        .cdb              (cdb),
        .robs_calculated  (robs_calculated),
        .rob_head_ptr     (rob_head_ptr),
        .flush_ip         (flush_ip),
        .rob_invalidated_n(rob_invalidated_n),
        .wdata            (wdata),
        .full             (full),
        .wdata_reg        (wdata_reg),
        .result_valid     (result_valid),
        .result           (result)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    task automatic next_drive_point();
        @(posedge clk);
        #1;
    endtask

    // watch n cycles for a result that must not come and end on a drive point
    task automatic hold_idle(input int n, input string what);
        repeat (n) begin
            @(negedge clk);
            check_true(!result_valid, what);
        end
        next_drive_point();
    endtask

    task automatic wait_result(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!result_valid && cycles < RESULT_TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        check_true(result_valid, "no load result arrived in time");
    endtask

    function automatic rob_tag_t take_tag();
        rob_tag_t t;
        t        = next_tag;
        next_tag = next_tag + 3'd1;
        return t;
    endfunction

    function automatic rv32i_word random_addr(input op_t op);
        rv32i_word a;
        a = ($urandom % MEM_WORDS) << 2;
        case (op)
            SH, LH, LHU: a = a + (($urandom % 2) << 1);
            SB, LB, LBU: a = a + ($urandom % 4);
            default: ;
        endcase
        return a;
    endfunction

    // base plus immediate with the low address bits kept in the base
    function automatic res_word make_entry(input op_t op, input rv32i_word addr,
                                           input rob_tag_t tag, input rv32i_reg data_reg);
        res_word   e;
        rv32i_word imm;
        imm          = ($urandom % 4) << 2;
        e            = '0;
        e.op         = op;
        e.src1_data  = addr - imm;
        e.src1_valid = 1'b1;
        e.src2_data  = imm;
        e.src2_valid = 1'b1;
        e.src2_reg   = data_reg;
        e.rd_tag     = tag;
        return e;
    endfunction

    task automatic ref_store(input op_t op, input rv32i_word addr, input rv32i_word data);
        int nbytes;
        int b;
        nbytes = (op == SW) ? 4 : (op == SH) ? 2 : 1;
        for (b = 0; b < nbytes; b++) begin
            ref_mem[addr[WORD_MSB:2]][8 * (int'(addr[1:0]) + b) +: 8] = data[8 * b +: 8];
        end
    endtask

    function automatic rv32i_word predict_load(input op_t op, input rv32i_word addr);
        rv32i_word word;
        logic [7:0]  byte_val;
        logic [15:0] half_val;
        word     = ref_mem[addr[WORD_MSB:2]];
        byte_val = word[8 * int'(addr[1:0]) +: 8];
        half_val = word[8 * int'(addr[1:0]) +: 16];
        case (op)
            LB:      return {{24{byte_val[7]}}, byte_val};
            LBU:     return {24'h0, byte_val};
            LH:      return {{16{half_val[15]}}, half_val};
            LHU:     return {16'h0, half_val};
            default: return word;
        endcase
    endfunction

    task automatic allocate(input res_word e);
        load   = 1'b1;
        res_in = e;
        next_drive_point();
        load   = 1'b0;
    endtask

    task automatic do_store(input op_t op, input rv32i_word addr, input rv32i_word data);
        rob_tag_t tag;
        rv32i_reg r;
        tag        = take_tag();
        r          = rv32i_reg'($urandom_range(1, 31));
        regfile[r] = data;
        allocate(make_entry(op, addr, tag, r));
        rob_head_ptr = tag;
        @(negedge clk);
        check_value("wdata_reg", wdata_reg, r);
        check_true(!result_valid, "store produced a load result");
        hold_idle(MEM_LATENCY, "store produced a load result");  // write lands here
        ref_store(op, addr, data);
    endtask

    task automatic do_load(input op_t op, input rv32i_word addr, input int hold);
        rob_tag_t  tag;
        rv32i_word exp;
        int        lat;
        tag = take_tag();
        exp = predict_load(op, addr);
        allocate(make_entry(op, addr, tag, '0));
        repeat (hold) begin
            @(negedge clk);
            check_true(!lsq_unit_i.data_read, "load issued before its tag reached the ROB head");
        end
        next_drive_point();
        rob_head_ptr = tag;
        wait_result(lat);
        check_value("result latency", lat, MEM_LATENCY + 1);
        check_value("result.data", result.data, exp);
        check_value("result.tag", result.tag, tag);
        next_drive_point();
    endtask

    task automatic test_stores_then_loads();
        rv32i_word a_w;
        rv32i_word a_h;
        rv32i_word a_b;
        repeat (3) begin
            a_w = random_addr(SW);
            a_h = random_addr(SH);
            a_b = random_addr(SB);
            do_store(SW, a_w, $urandom);
            do_store(SH, a_h, $urandom);
            do_store(SB, a_b, $urandom);
            do_load(LW, a_w, 1);
            do_load(LH, a_h, 1);
            do_load(LHU, a_h, 1);
            do_load(LB, a_b, 1);
            do_load(LBU, a_b, 1);
        end
    endtask

    task automatic test_latency();
        do_load(LW, random_addr(LW), 8);
        do_load(LBU, random_addr(LBU), 5);
    endtask

    task automatic test_operand_wakeup();
        res_word   e;
        rob_tag_t  tag;
        rob_tag_t  src;
        rv32i_word a;
        rv32i_word exp;
        int        lat;
        a   = random_addr(LW);
        exp = predict_load(LW, a);
        tag = take_tag();
        src = tag + 3'd4;  // producer still executing
        e   = make_entry(LW, a, tag, '0);
        cdb[src].data = ~e.src1_data;  // stale slot that must not be used
        allocate('{default: '0, op: LW, src1_tag: src, src1_data: $urandom,
                   src2_data: e.src2_data, src2_valid: 1'b1, rd_tag: tag});
        rob_head_ptr = tag;
        repeat (10) begin
            @(negedge clk);
            check_true(!lsq_unit_i.data_read, "load requested memory without its base");
            check_true(!result_valid, "load completed without its base");
        end
        next_drive_point();
        cdb[src].data        = e.src1_data;
        robs_calculated[src] = 1'b1;
        wait_result(lat);
        check_value("result latency", lat, MEM_LATENCY + 2);  // one edge for the wakeup
        check_value("result.data", result.data, exp);
        check_value("result.tag", result.tag, tag);
        next_drive_point();
        robs_calculated = '0;
    endtask

    task automatic test_order_and_full();
        op_t       ops [LSQ_DEPTH];
        rob_tag_t  tags [LSQ_DEPTH];
        rv32i_word exps [LSQ_DEPTH];
        rv32i_word a;
        rob_tag_t  extra;
        int        lat;
        int        i;
        ops = '{LW, LH, LBU, LB};
        for (i = 0; i < LSQ_DEPTH; i++) begin
            tags[i] = take_tag();
            a       = random_addr(ops[i]);
            exps[i] = predict_load(ops[i], a);
            allocate(make_entry(ops[i], a, tags[i], '0));
        end
        @(negedge clk);
        check_value("full", full, 1'b1);
        next_drive_point();
        extra = take_tag();
        allocate(make_entry(LW, random_addr(LW), extra, '0));  // dropped since the queue is full
        rob_head_ptr = tags[1];  // second entry may not pass the first
        hold_idle(8, "load issued ahead of an older queue entry");
        for (i = 0; i < LSQ_DEPTH; i++) begin
            rob_head_ptr = tags[i];
            wait_result(lat);
            check_value("result latency", lat, MEM_LATENCY + 1);
            check_value("result.data", result.data, exps[i]);
            check_value("result.tag", result.tag, tags[i]);
            next_drive_point();
        end
        @(negedge clk);
        check_value("full", full, 1'b0);
        next_drive_point();
        rob_head_ptr = extra;
        hold_idle(8, "load allocated while full was executed");
    endtask

    task automatic test_flush();
        rob_tag_t  ld_tag;
        rob_tag_t  st_tag;
        rv32i_word a;
        rv32i_reg  r;
        a          = random_addr(SW);
        ld_tag     = take_tag();
        st_tag     = take_tag();
        r          = rv32i_reg'($urandom_range(1, 31));
        regfile[r] = ~predict_load(LW, a);
        allocate(make_entry(LW, a, ld_tag, '0));
        allocate(make_entry(SW, a, st_tag, r));
        flush_ip                  = 1'b1;
        rob_invalidated_n[ld_tag] = 1'b0;
        rob_invalidated_n[st_tag] = 1'b0;
        next_drive_point();
        flush_ip          = 1'b0;
        rob_invalidated_n = '1;
        rob_head_ptr      = ld_tag;  // squashed load still drains through memory
        hold_idle(MEM_LATENCY + 4, "squashed load returned a result");
        do_load(LW, a, 1);  // old word since the squashed store never wrote
    endtask

    initial begin
        int i;
        void'($urandom(32'h13f8_3900));
        rst               = 1'b1;
        load              = 1'b0;
        res_in            = '0;
        robs_calculated   = '0;
        rob_head_ptr      = 3'd7;
        flush_ip          = 1'b0;
        rob_invalidated_n = '1;
        next_tag          = '0;
        checks            = 0;
        errors            = 0;
        for (i = 0; i < ROB_ENTRIES; i++) begin
            cdb[i] = '0;
        end
        for (i = 0; i < 32; i++) begin
            regfile[i] = '0;
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;  // memory clears on reset
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("full", full, 1'b1);  // one cycle in RESET
        check_value("result_valid", result_valid, 1'b0);
        next_drive_point();
        test_stores_then_loads();
        test_latency();
        test_operand_wakeup();
        test_order_and_full();
        test_flush();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog: tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("checks: %0d  errors: %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* tomasula_types.sv */
package tomasula_types;

    parameter int ROB_ENTRIES = 8;
    parameter int ROB_TAG_W   = $clog2(ROB_ENTRIES);

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // memory ops start at 8, loads are everything above SW
    typedef enum logic [3:0] {
        BRANCH  = 4'd0,
        JAL     = 4'd1,
        JALR    = 4'd2,
        LUI     = 4'd3,
        AUIPC   = 4'd4,
        ALU_REG = 4'd5,
        ALU_IMM = 4'd6,
        NOP     = 4'd7,
        SB      = 4'd8,
        SH      = 4'd9,
        SW      = 4'd10,
        LB      = 4'd11,
        LH      = 4'd12,
        LW      = 4'd13,
        LBU     = 4'd14,
        LHU     = 4'd15
    } op_t;

    // entry handed over by the issue stage
    typedef struct packed {
        op_t                   op;
        logic [2:0]            funct3;
        logic                  funct7;
        rob_tag_t              src1_tag;
        rv32i_types::rv32i_word src1_data;  // base register
        logic                  src1_valid;
        rob_tag_t              src2_tag;
        rv32i_types::rv32i_word src2_data;  // immediate offset
        logic                  src2_valid;
        rv32i_types::rv32i_reg src2_reg;    // store data register
        rob_tag_t              rd_tag;
        rv32i_types::rv32i_word pc;
    } res_word;

    typedef struct packed {
        rv32i_types::rv32i_word data;
        rob_tag_t               tag;
    } cdb_data;

    typedef struct packed {
        op_t                    op;
        logic [2:0]             funct3;
        logic                   funct7;
        rv32i_types::rv32i_word src1_data;
        rv32i_types::rv32i_word src2_data;
        rv32i_types::rv32i_word pc;
        rob_tag_t               tag;
    } alu_word;

    typedef struct packed {
        rob_tag_t               tag;
        rv32i_types::rv32i_word data;
    } load_result;

endpackage
